//--- Bender.yml
package:
  name: pet_top

sources:
  - verilog/pet_pkg.sv
  - verilog/frame_timer.sv
  - verilog/vital_stats.sv
  - verilog/mood_sequencer.sv
  - verilog/pet_top.sv
  - target: test
    files:
      - dv/tb_pet_top.sv

//--- dv/tb_pet_top.sv
`default_nettype none

// testbench for the virtual pet top level
module tb_pet_top;

	timeunit 1ns;
	timeprecision 1ps;

	logic                 frame_clk;
	logic                 reset;
	logic [7:0]           key;
	logic [7:0]           sprite;
	pet_pkg::mood_e       mood;
	pet_pkg::stat_t       health;
	pet_pkg::stat_t       satiety;
	pet_pkg::stat_t       affection;

	// reference model state
	pet_pkg::mood_e       m_mood;
	logic [3:0]           m_frame;
	int                   m_count;
	pet_pkg::stat_event_e m_event;
	pet_pkg::stat_t       m_health;
	pet_pkg::stat_t       m_satiety;
	pet_pkg::stat_t       m_affection;
	pet_pkg::sprite_u     m_sprite;

	pet_top u_dut (
		.frame_clk (frame_clk),
		.reset     (reset),
		.key       (key),
		.sprite    (sprite),
		.mood      (mood),
		.health    (health),
		.satiety   (satiety),
		.affection (affection)
	);

	// 8 ns frame clock
	always #4 frame_clk = ~frame_clk;

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------

	task automatic check_mood(input pet_pkg::mood_e exp, input pet_pkg::mood_e act);
		if (act !== exp) begin
			$display("[FAIL] %0t mood expected %s got %s", $time, exp.name(), act.name());
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_sprite(input pet_pkg::sprite_u exp, input pet_pkg::sprite_u act);
		if (act.raw !== exp.raw) begin
			$display("[FAIL] %0t sprite expected %h got %h", $time, exp.raw, act.raw);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_stat(input string name, input pet_pkg::stat_t exp,
			input pet_pkg::stat_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timed out waiting for %s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	// ----------------------------------------
	// cycle model
	// ----------------------------------------

	function automatic pet_pkg::stat_t raise_stat(input pet_pkg::stat_t v);
		return (v == 4'd15) ? v : v + 4'd1;
	endfunction

	function automatic pet_pkg::stat_t lower_stat(input pet_pkg::stat_t v);
		return (v == 4'd0) ? v : v - 4'd1;
	endfunction

	// sprite shown for a mood and idle frame
	function automatic pet_pkg::sprite_u sprite_for(input pet_pkg::mood_e md,
			input logic [3:0] fr);
		pet_pkg::sprite_u s;
		s.raw = 8'h00;
		case (md)
			pet_pkg::MOOD_IDLE_HAPPY: s.fields = '{4'hA, fr};
			pet_pkg::MOOD_IDLE_SAD:   s.fields = '{4'hB, fr};
			pet_pkg::MOOD_FEED_SHOW:  s.raw = 8'hC1;
			pet_pkg::MOOD_PET_SHOW:   s.raw = 8'hD1;
			pet_pkg::MOOD_UPSET, pet_pkg::MOOD_DEAD: s.raw = 8'h01;
			default: s.raw = 8'h00;
		endcase
		return s;
	endfunction

	// one frame of the pet rules
	// k is the key seen at this edge
	task automatic model_step(input logic [7:0] k);
		pet_pkg::mood_e       n_mood;
		logic [3:0]           n_frame;
		pet_pkg::stat_event_e n_event;
		logic                 healthy;
		logic                 empty;
		logic                 done;
		logic                 changed;
		healthy = (m_health >= 5) && (m_satiety >= 5) && (m_affection >= 5);
		empty = (m_health == 0) || (m_satiety == 0) || (m_affection == 0);
		done = (m_count == 20);
		n_mood = m_mood;
		n_frame = m_frame;
		case (m_mood)
			pet_pkg::MOOD_START: n_mood = pet_pkg::MOOD_CHECK;
			pet_pkg::MOOD_CHECK: begin
				n_frame = 4'd1;
				if (healthy) n_mood = pet_pkg::MOOD_IDLE_HAPPY;
				else if (empty) n_mood = pet_pkg::MOOD_DEAD;
				else n_mood = pet_pkg::MOOD_IDLE_SAD;
			end
			pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD, pet_pkg::MOOD_UPSET: begin
				if (k == 8'h14) n_mood = pet_pkg::MOOD_FEED;
				else if (k == 8'h1A) n_mood = pet_pkg::MOOD_PET;
				else if (done && (m_mood == pet_pkg::MOOD_UPSET || m_frame == 4'd8))
					n_mood = pet_pkg::MOOD_CHECK;
				else if (done) n_frame = m_frame + 4'd1;
			end
			pet_pkg::MOOD_FEED: begin
				if (done) begin
					n_mood = (m_satiety > 9) ? pet_pkg::MOOD_UPSET
						: pet_pkg::MOOD_FEED_SHOW;
				end
			end
			pet_pkg::MOOD_PET: begin
				if (done) begin
					n_mood = (m_affection > 9) ? pet_pkg::MOOD_UPSET
						: pet_pkg::MOOD_PET_SHOW;
				end
			end
			pet_pkg::MOOD_FEED_SHOW: begin
				// timer wins over keys here
				if (done) n_mood = pet_pkg::MOOD_CHECK;
				else if (k == 8'h14) n_mood = pet_pkg::MOOD_FEED;
				else if (k == 8'h1A) n_mood = pet_pkg::MOOD_PET;
			end
			pet_pkg::MOOD_PET_SHOW: begin
				if (done) n_mood = pet_pkg::MOOD_CHECK;
			end
			default: begin
				if (k == 8'h16) n_mood = pet_pkg::MOOD_START;
			end
		endcase
		changed = (n_mood != m_mood) || (n_frame != m_frame);
		n_event = pet_pkg::EV_NONE;
		if (changed) begin
			case (n_mood)
				pet_pkg::MOOD_START:     n_event = pet_pkg::EV_LOAD;
				pet_pkg::MOOD_FEED_SHOW: n_event = pet_pkg::EV_FEED;
				pet_pkg::MOOD_PET_SHOW:  n_event = pet_pkg::EV_PET;
				pet_pkg::MOOD_UPSET:     n_event = pet_pkg::EV_SCOLD;
				pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD: begin
					if (n_frame == 4'd8) n_event = pet_pkg::EV_DECAY;
				end
				default: n_event = pet_pkg::EV_NONE;
			endcase
		end
		// vitals follow the event issued one edge earlier
		case (m_event)
			pet_pkg::EV_LOAD: begin
				m_health = 4'd5;
				m_satiety = 4'd5;
				m_affection = 4'd5;
			end
			pet_pkg::EV_DECAY: begin
				m_health = lower_stat(m_health);
				m_satiety = lower_stat(m_satiety);
				m_affection = lower_stat(m_affection);
			end
			pet_pkg::EV_FEED: begin
				m_health = raise_stat(m_health);
				m_satiety = raise_stat(m_satiety);
			end
			pet_pkg::EV_PET: begin
				m_health = raise_stat(m_health);
				m_affection = raise_stat(m_affection);
			end
			pet_pkg::EV_SCOLD: m_health = lower_stat(m_health);
			default: ;
		endcase
		if (changed) m_count = 0;
		else if (m_count < 20) m_count = m_count + 1;
		m_mood = n_mood;
		m_frame = n_frame;
		m_event = n_event;
		m_sprite = sprite_for(n_mood, n_frame);
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	// drive k and step the model at the edge
	// outputs compared just after it
	task automatic run_cycle(input logic [7:0] k);
		key = k;
		@(posedge frame_clk);
		model_step(k);
		#1;
		check_mood(m_mood, mood);
		check_sprite(m_sprite, sprite);
		check_stat("health", m_health, health);
		check_stat("satiety", m_satiety, satiety);
		check_stat("affection", m_affection, affection);
	endtask

	// wait until mood is a or b while holding key k
	task automatic wait_for_mood(input pet_pkg::mood_e a, input pet_pkg::mood_e b,
			input int limit, input logic [7:0] k);
		int n;
		n = 0;
		while (mood != a && mood != b) begin
			if (n == limit) begin
				timeout_fail({a.name(), " or ", b.name()});
			end else begin
				run_cycle(k);
				n++;
			end
		end
	endtask

	// mostly no key with some game keys and some junk
	function automatic logic [7:0] random_key();
		int r;
		r = $urandom % 16;
		if (r < 9) return 8'h00;
		if (r < 11) return 8'h14;
		if (r < 13) return 8'h1A;
		if (r == 13) return 8'h16;
		return 8'($urandom);
	endfunction

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial begin
		void'($urandom(78));
		frame_clk = 1'b0;
		reset = 1'b1;
		key = 8'h00;
		m_mood = pet_pkg::MOOD_START;
		m_frame = 4'd1;
		m_count = 0;
		m_event = pet_pkg::EV_NONE;
		m_health = 4'd5;
		m_satiety = 4'd5;
		m_affection = 4'd5;
		m_sprite.raw = 8'h00;
		repeat (8) @(posedge frame_clk);
		#1;
		reset = 1'b0;

		// reset values and then start and check
		check_mood(pet_pkg::MOOD_START, mood);
		check_sprite(8'h00, sprite);
		check_stat("health", 4'd5, health);
		check_stat("satiety", 4'd5, satiety);
		check_stat("affection", 4'd5, affection);
		run_cycle(8'h00);
		run_cycle(8'h00);
		check_mood(pet_pkg::MOOD_IDLE_HAPPY, mood);
		check_sprite(8'hA1, sprite);

		// idle pass with 21 frames per sprite
		repeat (20) run_cycle(8'h00);
		check_sprite(8'hA1, sprite);
		run_cycle(8'h00);
		check_sprite(8'hA2, sprite);
		repeat (6 * 21) run_cycle(8'h00);
		check_sprite(8'hA8, sprite);
		run_cycle(8'h00);
		check_stat("health", 4'd4, health);
		check_stat("satiety", 4'd4, satiety);
		check_stat("affection", 4'd4, affection);
		wait_for_mood(pet_pkg::MOOD_IDLE_SAD, pet_pkg::MOOD_IDLE_SAD, 40, 8'h00);
		check_sprite(8'hB1, sprite);

		// held feed key is ignored while eating
		run_cycle(8'h14);
		check_mood(pet_pkg::MOOD_FEED, mood);
		check_sprite(8'h00, sprite);
		repeat (5) run_cycle(8'h14);
		check_mood(pet_pkg::MOOD_FEED, mood);
		wait_for_mood(pet_pkg::MOOD_FEED_SHOW, pet_pkg::MOOD_FEED_SHOW, 30, 8'h00);
		check_sprite(8'hC1, sprite);
		run_cycle(8'h00);
		check_stat("health", 4'd5, health);
		check_stat("satiety", 4'd5, satiety);
		for (int i = 0; i < 10; i++) begin
			run_cycle(8'h14);
			wait_for_mood(pet_pkg::MOOD_FEED_SHOW, pet_pkg::MOOD_UPSET, 30, 8'h00);
			if (mood == pet_pkg::MOOD_UPSET) break;
		end
		check_mood(pet_pkg::MOOD_UPSET, mood);
		check_sprite(8'h01, sprite);
		run_cycle(8'h00);
		check_stat("health", 4'd9, health);
		check_stat("satiety", 4'd10, satiety);

		// petting until affection is full
		for (int i = 0; i < 10; i++) begin
			run_cycle(8'h1A);
			check_mood(pet_pkg::MOOD_PET, mood);
			wait_for_mood(pet_pkg::MOOD_PET_SHOW, pet_pkg::MOOD_UPSET, 30, 8'h00);
			if (mood == pet_pkg::MOOD_UPSET) break;
			check_sprite(8'hD1, sprite);
			wait_for_mood(pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD, 30, 8'h00);
		end
		check_mood(pet_pkg::MOOD_UPSET, mood);
		run_cycle(8'h00);
		check_stat("health", 4'd14, health);
		check_stat("affection", 4'd10, affection);

		// starve to death and revive with restart only
		wait_for_mood(pet_pkg::MOOD_DEAD, pet_pkg::MOOD_DEAD, 4000, 8'h00);
		check_sprite(8'h01, sprite);
		run_cycle(8'h14);
		check_mood(pet_pkg::MOOD_DEAD, mood);
		run_cycle(8'h1A);
		check_mood(pet_pkg::MOOD_DEAD, mood);
		run_cycle(8'h16);
		check_mood(pet_pkg::MOOD_START, mood);
		run_cycle(8'h00);
		check_stat("health", 4'd5, health);
		check_stat("satiety", 4'd5, satiety);
		check_stat("affection", 4'd5, affection);

		// one decay first so health can reach the ceiling before satiety is full
		wait_for_mood(pet_pkg::MOOD_IDLE_SAD, pet_pkg::MOOD_IDLE_SAD, 200, 8'h00);
		for (int i = 0; i < 5; i++) begin
			run_cycle(8'h14);
			wait_for_mood(pet_pkg::MOOD_FEED_SHOW, pet_pkg::MOOD_FEED_SHOW, 30, 8'h00);
		end
		for (int i = 0; i < 6; i++) begin
			run_cycle(8'h1A);
			wait_for_mood(pet_pkg::MOOD_PET_SHOW, pet_pkg::MOOD_PET_SHOW, 30, 8'h00);
			wait_for_mood(pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD, 30, 8'h00);
		end
		check_stat("health", 4'd15, health);
		run_cycle(8'h14);
		wait_for_mood(pet_pkg::MOOD_FEED_SHOW, pet_pkg::MOOD_FEED_SHOW, 30, 8'h00);
		run_cycle(8'h00);
		check_stat("health", 4'd15, health);
		check_stat("satiety", 4'd10, satiety);
		check_stat("affection", 4'd10, affection);

		// repeated scolds pin health at zero
		for (int i = 0; i < 16; i++) begin
			run_cycle(8'h14);
			wait_for_mood(pet_pkg::MOOD_UPSET, pet_pkg::MOOD_UPSET, 30, 8'h00);
		end
		run_cycle(8'h00);
		check_stat("health", 4'd0, health);
		wait_for_mood(pet_pkg::MOOD_DEAD, pet_pkg::MOOD_DEAD, 30, 8'h00);
		run_cycle(8'h16);
		check_mood(pet_pkg::MOOD_START, mood);

		// long random run against the model
		repeat (20000) run_cycle(random_key());

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
verilog/pet_pkg.sv
verilog/frame_timer.sv
verilog/vital_stats.sv
verilog/mood_sequencer.sv
verilog/pet_top.sv
dv/tb_pet_top.sv

//--- verilog/frame_timer.sv
`default_nettype none

// dwell counter for timed moods
// counts frames since the sequencer last changed mood or idle frame
module frame_timer (
	input  wire logic frame_clk,
	input  wire logic reset,
	input  wire logic dwell_clear,
	output logic      dwell_done
);

	// frames spent in the current mood, minus one
	logic [4:0] count;

	// ----------------------------------------
	// counter
	// ----------------------------------------

	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (dwell_clear) begin
			// new mood entered at this edge
			count <= '0;
		end else if (count != pet_pkg::DWELL_LAST) begin
			count <= count + 5'd1;
		end
		// otherwise hold at the last count
		// dead sits here until restart
	end

	// high for as long as the count rests at the limit
	assign dwell_done = (count == pet_pkg::DWELL_LAST);

endmodule

`default_nettype wire

//--- verilog/mood_sequencer.sv
`default_nettype none

// mood FSM
// picks the next mood from key, dwell timer and vital flags,
// issues stat events and registers the sprite code
module mood_sequencer (
	input  wire logic                 frame_clk,
	input  wire logic                 reset,
	input  wire logic [7:0]           key,
	input  wire logic                 dwell_done,
	input  wire logic                 all_healthy,
	input  wire logic                 any_empty,
	input  wire logic                 satiety_full,
	input  wire logic                 affection_full,
	output logic                      dwell_clear,
	output pet_pkg::stat_event_e      stat_event,
	output pet_pkg::mood_e            mood,
	output pet_pkg::sprite_u          sprite
);

	pet_pkg::mood_e       mood_d;
	logic [3:0]           frame_q;
	logic [3:0]           frame_d;
	pet_pkg::stat_event_e event_d;
	pet_pkg::sprite_u     sprite_d;
	logic                 key_feed;
	logic                 key_pet;
	logic                 key_restart;

	// key decode, sampled once per frame
	assign key_feed    = (key == pet_pkg::KEY_FEED);
	assign key_pet     = (key == pet_pkg::KEY_PET);
	assign key_restart = (key == pet_pkg::KEY_RESTART);

	// ----------------------------------------
	// next mood and idle frame
	// ----------------------------------------

	always_comb begin
		mood_d  = mood;
		frame_d = frame_q;
		case (mood)
			pet_pkg::MOOD_START: begin
				mood_d = pet_pkg::MOOD_CHECK;
			end
			pet_pkg::MOOD_CHECK: begin
				// every idle pass starts from frame 1
				frame_d = pet_pkg::FRAME_FIRST;
				if (all_healthy) begin
					mood_d = pet_pkg::MOOD_IDLE_HAPPY;
				end else if (any_empty) begin
					mood_d = pet_pkg::MOOD_DEAD;
				end else begin
					mood_d = pet_pkg::MOOD_IDLE_SAD;
				end
			end
			pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD, pet_pkg::MOOD_UPSET: begin
				// keys win over the timer here
				if (key_feed) begin
					mood_d = pet_pkg::MOOD_FEED;
				end else if (key_pet) begin
					mood_d = pet_pkg::MOOD_PET;
				end else if (dwell_done) begin
					if (mood == pet_pkg::MOOD_UPSET || frame_q == pet_pkg::IDLE_FRAMES) begin
						mood_d = pet_pkg::MOOD_CHECK;
					end else begin
						// next animation frame, same mood
						frame_d = frame_q + 4'd1;
					end
				end
			end
			pet_pkg::MOOD_FEED: begin
				// keys ignored while eating
				if (dwell_done) begin
					mood_d = satiety_full ? pet_pkg::MOOD_UPSET : pet_pkg::MOOD_FEED_SHOW;
				end
			end
			pet_pkg::MOOD_PET: begin
				if (dwell_done) begin
					mood_d = affection_full ? pet_pkg::MOOD_UPSET : pet_pkg::MOOD_PET_SHOW;
				end
			end
			pet_pkg::MOOD_FEED_SHOW: begin
				// timer first, then keys as in idle
				if (dwell_done) begin
					mood_d = pet_pkg::MOOD_CHECK;
				end else if (key_feed) begin
					mood_d = pet_pkg::MOOD_FEED;
				end else if (key_pet) begin
					mood_d = pet_pkg::MOOD_PET;
				end
			end
			pet_pkg::MOOD_PET_SHOW: begin
				if (dwell_done) begin
					mood_d = pet_pkg::MOOD_CHECK;
				end
			end
			pet_pkg::MOOD_DEAD: begin
				// only restart leaves
				if (key_restart) begin
					mood_d = pet_pkg::MOOD_START;
				end
			end
			default: begin
				// unused encodings recover through start
				mood_d = pet_pkg::MOOD_START;
			end
		endcase
	end

	// any change of mood or idle frame restarts the dwell count
	assign dwell_clear = (mood_d != mood) || (frame_d != frame_q);

	// ----------------------------------------
	// stat events and sprite
	// ----------------------------------------

	// event tied to the mood being entered, none otherwise
	always_comb begin
		event_d = pet_pkg::EV_NONE;
		if (dwell_clear) begin
			case (mood_d)
				pet_pkg::MOOD_START:     event_d = pet_pkg::EV_LOAD;
				pet_pkg::MOOD_FEED_SHOW: event_d = pet_pkg::EV_FEED;
				pet_pkg::MOOD_PET_SHOW:  event_d = pet_pkg::EV_PET;
				pet_pkg::MOOD_UPSET:     event_d = pet_pkg::EV_SCOLD;
				pet_pkg::MOOD_IDLE_HAPPY, pet_pkg::MOOD_IDLE_SAD: begin
					// decay once per pass, on the last frame
					if (frame_d == pet_pkg::IDLE_FRAMES) begin
						event_d = pet_pkg::EV_DECAY;
					end
				end
				default: event_d = pet_pkg::EV_NONE;
			endcase
		end
	end

	// sprite for the upcoming mood
	// blank neutral face unless listed below
	always_comb begin
		sprite_d.fields.group = pet_pkg::GROUP_NEUTRAL;
		sprite_d.fields.frame = pet_pkg::FRAME_BLANK;
		case (mood_d)
			pet_pkg::MOOD_IDLE_HAPPY: begin
				sprite_d.fields.group = pet_pkg::GROUP_IDLE_HAPPY;
				sprite_d.fields.frame = frame_d;
			end
			pet_pkg::MOOD_IDLE_SAD: begin
				sprite_d.fields.group = pet_pkg::GROUP_IDLE_SAD;
				sprite_d.fields.frame = frame_d;
			end
			pet_pkg::MOOD_FEED_SHOW: begin
				sprite_d.fields.group = pet_pkg::GROUP_FEED;
				sprite_d.fields.frame = pet_pkg::FRAME_FIRST;
			end
			pet_pkg::MOOD_PET_SHOW: begin
				sprite_d.fields.group = pet_pkg::GROUP_PET;
				sprite_d.fields.frame = pet_pkg::FRAME_FIRST;
			end
			pet_pkg::MOOD_UPSET, pet_pkg::MOOD_DEAD: begin
				// sad face
				sprite_d.fields.frame = pet_pkg::FRAME_FIRST;
			end
			default: begin
				sprite_d.fields.frame = pet_pkg::FRAME_BLANK;
			end
		endcase
	end

	// ----------------------------------------
	// state registers
	// ----------------------------------------

	// mood and sprite move together at the same edge
	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			mood       <= pet_pkg::MOOD_START;
			frame_q    <= pet_pkg::FRAME_FIRST;
			stat_event <= pet_pkg::EV_NONE;
			sprite.raw <= 8'h00;
		end else begin
			mood       <= mood_d;
			frame_q    <= frame_d;
			stat_event <= event_d;
			sprite     <= sprite_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pet_pkg.sv
`default_nettype none

package pet_pkg;

	// ----------------------------------------
	// mood and vital types
	// ----------------------------------------

	// top level moods
	// idle moods share one state each, frame index kept aside
	typedef enum logic [3:0] {
		MOOD_START,
		MOOD_CHECK,
		MOOD_IDLE_HAPPY,
		MOOD_IDLE_SAD,
		MOOD_FEED,
		MOOD_FEED_SHOW,
		MOOD_PET,
		MOOD_PET_SHOW,
		MOOD_UPSET,
		MOOD_DEAD
	} mood_e;

	// one vital, unsigned, saturates at both ends
	typedef logic [3:0] stat_t;

	// update requested of the stats bank, one per frame at most
	typedef enum logic [2:0] {
		EV_NONE,
		EV_LOAD,
		EV_DECAY,
		EV_FEED,
		EV_PET,
		EV_SCOLD
	} stat_event_e;

	// sprite byte, high nibble picks the group, low nibble the frame
	typedef struct packed {
		logic [3:0] group;
		logic [3:0] frame;
	} sprite_fields_t;

	// raw byte for the display side, fields for the sequencer
	typedef union packed {
		logic [7:0]     raw;
		sprite_fields_t fields;
	} sprite_u;

	// ----------------------------------------
	// sprite codes
	// ----------------------------------------

	localparam logic [3:0] GROUP_NEUTRAL    = 4'h0;
	localparam logic [3:0] GROUP_IDLE_HAPPY = 4'hA;
	localparam logic [3:0] GROUP_IDLE_SAD   = 4'hB;
	localparam logic [3:0] GROUP_FEED       = 4'hC;
	localparam logic [3:0] GROUP_PET        = 4'hD;

	// frame 0 of neutral is the blank face, frame 1 the sad one
	localparam logic [3:0] FRAME_BLANK = 4'h0;
	localparam logic [3:0] FRAME_FIRST = 4'h1;

	// keyboard usage codes
	localparam logic [7:0] KEY_FEED    = 8'h14;
	localparam logic [7:0] KEY_PET     = 8'h1A;
	localparam logic [7:0] KEY_RESTART = 8'h16;

	// ----------------------------------------
	// timing and game limits
	// ----------------------------------------

	// last dwell count, so a timed mood lasts 21 frames
	localparam logic [4:0] DWELL_LAST  = 5'd20;
	localparam logic [3:0] IDLE_FRAMES = 4'd8;

	localparam stat_t STAT_INIT   = 4'd5;
	localparam stat_t STAT_MAX    = 4'd15;
	localparam stat_t HEALTHY_MIN = 4'd5;
	localparam stat_t FULL_LIMIT  = 4'd9;

endpackage

`default_nettype wire

//--- verilog/pet_top.sv
`default_nettype none

// virtual pet top
// timer and stats bank side by side, sequencer ties them to the key
module pet_top (
	input  wire logic           frame_clk,
	input  wire logic           reset,
	input  wire logic [7:0]     key,
	output wire logic [7:0]     sprite,
	output wire pet_pkg::mood_e mood,
	output wire pet_pkg::stat_t health,
	output wire pet_pkg::stat_t satiety,
	output wire pet_pkg::stat_t affection
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------

	// timer handshake
	logic dwell_clear;
	logic dwell_done;

	// stats request and flags
	pet_pkg::stat_event_e stat_event;
	logic                 all_healthy;
	logic                 any_empty;
	logic                 satiety_full;
	logic                 affection_full;

	// sprite in its decoded form
	pet_pkg::sprite_u seq_sprite;

	// ----------------------------------------
	// blocks
	// ----------------------------------------

	frame_timer u_timer (
		.frame_clk   (frame_clk),
		.reset       (reset),
		.dwell_clear (dwell_clear),
		.dwell_done  (dwell_done)
	);

	vital_stats u_stats (
		.frame_clk      (frame_clk),
		.reset          (reset),
		.stat_event     (stat_event),
		.health         (health),
		.satiety        (satiety),
		.affection      (affection),
		.all_healthy    (all_healthy),
		.any_empty      (any_empty),
		.satiety_full   (satiety_full),
		.affection_full (affection_full)
	);

	mood_sequencer u_sequencer (
		.frame_clk      (frame_clk),
		.reset          (reset),
		.key            (key),
		.dwell_done     (dwell_done),
		.all_healthy    (all_healthy),
		.any_empty      (any_empty),
		.satiety_full   (satiety_full),
		.affection_full (affection_full),
		.dwell_clear    (dwell_clear),
		.stat_event     (stat_event),
		.mood           (mood),
		.sprite         (seq_sprite)
	);

	// display takes the raw byte
	assign sprite = seq_sprite.raw;

endmodule

`default_nettype wire

//--- verilog/vital_stats.sv
`default_nettype none

// vitals bank
// health, satiety and affection, all saturating 0..15
module vital_stats (
	input  wire logic                 frame_clk,
	input  wire logic                 reset,
	input  wire pet_pkg::stat_event_e stat_event,
	output pet_pkg::stat_t            health,
	output pet_pkg::stat_t            satiety,
	output pet_pkg::stat_t            affection,
	output logic                      all_healthy,
	output logic                      any_empty,
	output logic                      satiety_full,
	output logic                      affection_full
);

	// ----------------------------------------
	// saturating helpers
	// ----------------------------------------

	// step up, stop at the ceiling
	function automatic pet_pkg::stat_t sat_inc(input pet_pkg::stat_t value);
		if (value == pet_pkg::STAT_MAX) begin
			return value;
		end
		return value + 4'd1;
	endfunction

	// step down, stop at zero
	function automatic pet_pkg::stat_t sat_dec(input pet_pkg::stat_t value);
		if (value == '0) begin
			return value;
		end
		return value - 4'd1;
	endfunction

	// ----------------------------------------
	// vital registers
	// ----------------------------------------

	// one event per frame
	// the event arrives one edge after its mood is entered
	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			health    <= pet_pkg::STAT_INIT;
			satiety   <= pet_pkg::STAT_INIT;
			affection <= pet_pkg::STAT_INIT;
		end else begin
			case (stat_event)
				pet_pkg::EV_LOAD: begin
					// restart after death
					health    <= pet_pkg::STAT_INIT;
					satiety   <= pet_pkg::STAT_INIT;
					affection <= pet_pkg::STAT_INIT;
				end
				pet_pkg::EV_DECAY: begin
					// end of an idle pass, everything wears down
					health    <= sat_dec(health);
					satiety   <= sat_dec(satiety);
					affection <= sat_dec(affection);
				end
				pet_pkg::EV_FEED: begin
					health  <= sat_inc(health);
					satiety <= sat_inc(satiety);
				end
				pet_pkg::EV_PET: begin
					health    <= sat_inc(health);
					affection <= sat_inc(affection);
				end
				pet_pkg::EV_SCOLD: begin
					// overfed or overpetted
					health <= sat_dec(health);
				end
				default: begin
					// no event, hold
					health    <= health;
					satiety   <= satiety;
					affection <= affection;
				end
			endcase
		end
	end

	// ----------------------------------------
	// threshold flags
	// ----------------------------------------

	// happy only if nothing is below the healthy floor
	assign all_healthy = (health >= pet_pkg::HEALTHY_MIN)
		&& (satiety >= pet_pkg::HEALTHY_MIN)
		&& (affection >= pet_pkg::HEALTHY_MIN);

	// any vital run dry means death at the next check
	assign any_empty = (health == '0) || (satiety == '0) || (affection == '0);

	// too full to take more food or attention
	assign satiety_full   = (satiety > pet_pkg::FULL_LIMIT);
	assign affection_full = (affection > pet_pkg::FULL_LIMIT);

endmodule

`default_nettype wire
